// File: filelist.f
verilog/fetch_pkg.sv
verilog/fetch_buffer_if.sv
verilog/fetch_buffer_ram.sv
verilog/fetch_sequencer.sv
verilog/fetch_occupancy.sv
verilog/fetch_assembler.sv
verilog/fetch_buffer.sv
verification/imem_model.sv
verification/fetch_buffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module fetch_buffer_tb -f filelist.f
./obj_dir/Vfetch_buffer_tb 2>&1 | tee sim.log
if grep -qx "Test passed" sim.log; then
  echo "Simulation finished without errors"
else
  echo "Pass line not found in sim.log"
  exit 1
fi

// File: verification/fetch_buffer_tb.sv
`timescale 1ns/1ps

module fetch_buffer_tb import fetch_pkg::*; ();

  localparam int clock_period = 20;
  localparam int num_tests = 6;
  localparam int cycles_per_test = 200;

  logic clock = 1'b0;
  logic reset;
  logic fetch_valid;
  logic fetch_fence;
  logic fetch_spec;
  addr_t fetch_addr;
  logic imem_ready;
  logic imem_error;
  word_t imem_rdata;
  logic fetch_ready;
  word_t fetch_rdata;
  logic fetch_error;
  logic imem_valid;
  addr_t imem_addr;
  addr_t pc;

  always #(clock_period / 2) clock = ~clock;

  fetch_buffer dut_i (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_fence (fetch_fence),
    .fetch_spec  (fetch_spec),
    .fetch_addr  (fetch_addr),
    .imem_ready  (imem_ready),
    .imem_error  (imem_error),
    .imem_rdata  (imem_rdata),
    .fetch_ready (fetch_ready),
    .fetch_rdata (fetch_rdata),
    .fetch_error (fetch_error),
    .imem_valid  (imem_valid),
    .imem_addr   (imem_addr)
  );

  imem_model mem_i (
    .clock      (clock),
    .reset      (reset),
    .imem_valid (imem_valid),
    .imem_addr  (imem_addr),
    .imem_ready (imem_ready),
    .imem_rdata (imem_rdata),
    .imem_error (imem_error)
  );

  // ========================================
  // Expected values
  // ========================================

  function automatic logic [15:0] content_half(addr_t h);
    return h[16:1] ^ 16'hA5C3 ^ {14'd0, h[4:3]};
  endfunction

  function automatic word_t expected_insn(addr_t h);
    logic [15:0] low;
    low = content_half(h);
    if (low[1:0] != 2'b11) begin
      return {16'h0000, low};                 // Compressed.
    end
    return {content_half(h + 32'd2), low};
  endfunction

  function automatic logic expected_error(addr_t h);
    logic [15:0] low;
    addr_t upper;
    low = content_half(h);
    upper = h + 32'd2;
    if (low[1:0] != 2'b11) begin
      return h[31:28] == 4'hF;
    end
    return (h[31:28] == 4'hF) || (upper[31:28] == 4'hF);
  endfunction

  function automatic addr_t next_pc(addr_t h);
    logic [15:0] low;
    low = content_half(h);
    return (low[1:0] == 2'b11) ? h + 32'd4 : h + 32'd2;
  endfunction

  // ========================================
  // Checks
  // ========================================

  task automatic stop_on_error(string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(string test, word_t expected, word_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("MISMATCH %s: expected %h, actual %h", test, expected, actual));
    end
  endtask

  task automatic check_addr(string test, addr_t expected, addr_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("MISMATCH %s: expected %h, actual %h", test, expected, actual));
    end
  endtask

  task automatic check_flag(string test, logic expected, logic actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("MISMATCH %s: expected %b, actual %b", test, expected, actual));
    end
  endtask

  // ========================================
  // Stimulus
  // ========================================

  // Called 1 ns after an edge, returns 1 ns after the edge that consumes.
  task automatic fetch_at(addr_t a, output word_t data, output logic err, output int waited);
    waited = 0;
    fetch_valid = 1'b1;
    fetch_fence = 1'b0;
    fetch_spec = 1'b0;
    fetch_addr = a;
    @(negedge clock);
    while (fetch_ready !== 1'b1) begin
      waited = waited + 1;
      @(negedge clock);
    end
    data = fetch_rdata;
    err = fetch_error;
    @(posedge clock);
    #1;
    fetch_valid = 1'b0;
  endtask

  task automatic check_fetch(string test, addr_t a);
    word_t data;
    logic err;
    int waited;
    fetch_at(a, data, err, waited);
    check_word($sformatf("%s data @%h", test, a), expected_insn(a), data);
    check_flag($sformatf("%s error @%h", test, a), expected_error(a), err);
  endtask

  task automatic walk(string test, addr_t start, int count);
    pc = start;
    repeat (count) begin
      check_fetch(test, pc);
      pc = next_pc(pc);
    end
  endtask

  task automatic redirect_to(string test, addr_t target);
    fetch_valid = 1'b1;
    fetch_spec = 1'b1;
    fetch_fence = 1'b0;
    fetch_addr = target;
    @(negedge clock);
    check_flag($sformatf("%s ready on spec", test), 1'b0, fetch_ready);
    @(posedge clock);
    #1;
    fetch_valid = 1'b0;
    fetch_spec = 1'b0;
    @(negedge clock);
    @(posedge clock);                         // Redirect edge.
    @(negedge clock);
    check_addr($sformatf("%s imem_addr", test), {target[31:2], 2'b00}, imem_addr);
    @(posedge clock);
    #1;
  endtask

  // ========================================
  // Tests
  // ========================================

  task automatic test_sequential();
    redirect_to("sequential", '0);
    walk("sequential", '0, 20);
  endtask

  task automatic test_misaligned();
    addr_t wide_addrs[3];
    wide_addrs = '{32'h0000_200A, 32'h0000_201E, 32'h0001_0FFE};
    foreach (wide_addrs[i]) begin
      redirect_to("misaligned", wide_addrs[i]);
      check_fetch("misaligned", wide_addrs[i]);
    end
  endtask

  task automatic test_redirect();
    redirect_to("redirect", 32'h0003_4560);
    walk("redirect", 32'h0003_4560, 10);
  endtask

  task automatic test_fence();
    word_t data;
    logic err;
    int waited;
    redirect_to("fence", '0);
    repeat (10) @(posedge clock);
    #1;
    redirect_to("fence spec", '0);           // Word 0 is buffered by now.
    fetch_valid = 1'b1;
    fetch_fence = 1'b1;
    fetch_addr = '0;
    @(negedge clock);
    check_flag("fence ready on request", 1'b0, fetch_ready);
    @(posedge clock);
    #1;
    fetch_at('0, data, err, waited);
    check_word("fence data @00000000", expected_insn('0), data);
    check_flag("fence error @00000000", expected_error('0), err);
    check_flag("fence stall length", 1'b1, waited >= fetch_depth);
    walk("fence refetch", next_pc('0), 12);
  endtask

  task automatic test_backpressure();
    while (pc[1]) begin                       // Start idling on a word boundary.
      check_fetch("backpressure align", pc);
      pc = next_pc(pc);
    end
    repeat (40) @(posedge clock);
    @(negedge clock);
    check_flag("backpressure imem_valid idle", 1'b0, imem_valid);
    @(posedge clock);
    #1;
    check_fetch("backpressure", pc);
    pc = next_pc(pc);
    @(negedge clock);
    check_flag("backpressure imem_valid resume", 1'b1, imem_valid);
    @(posedge clock);
    #1;
  endtask

  task automatic test_errors();
    redirect_to("error region", 32'hF000_0040);
    walk("error region", 32'hF000_0040, 8);
    redirect_to("error clean", 32'h0000_0800);
    walk("error clean", 32'h0000_0800, 6);
  endtask

  initial begin
    #(num_tests * cycles_per_test * clock_period);
    $display("Watchdog expired before all tests finished");
    $display("Test failed");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    reset = 1'b1;
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    fetch_spec = 1'b0;
    fetch_addr = '0;
    pc = '0;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    repeat (2) @(posedge clock);
    #1;
    test_sequential();
    test_misaligned();
    test_redirect();
    test_fence();
    test_backpressure();
    test_errors();
    $display("Test passed");
    $finish;
  end

endmodule

// File: verification/imem_model.sv
`timescale 1ns/1ps

module imem_model import fetch_pkg::*; (
  input logic clock,
  input logic reset,
  input logic imem_valid,
  input addr_t imem_addr,
  output logic imem_ready,
  output word_t imem_rdata,
  output logic imem_error
);

  logic [15:0] lfsr;
  logic [15:0] lfsr_a;
  logic [15:0] lfsr_b;
  logic [1:0] draw;
  logic pending;
  logic [1:0] wait_cnt;

  // Word index bits fold into the opcode bits so 32-bit words also start mid-word.
  function automatic logic [15:0] content_half(addr_t h);
    return h[16:1] ^ 16'hA5C3 ^ {14'd0, h[4:3]};
  endfunction

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  assign lfsr_a = lfsr_step(lfsr);
  assign lfsr_b = lfsr_step(lfsr_a);
  assign draw = {lfsr_a[0], lfsr_b[0]};       // One bit per step.

  // Data always follows the current address.
  assign imem_rdata = {content_half({imem_addr[31:2], 2'b10}),
                       content_half({imem_addr[31:2], 2'b00})};
  assign imem_error = imem_addr[31:28] == 4'hF;

  always @(posedge clock) begin
    if (reset) begin
      lfsr <= 16'd31480;
      pending <= 1'b0;
      wait_cnt <= '0;
      imem_ready <= 1'b0;
    end else begin
      imem_ready <= 1'b0;
      if (!imem_valid || imem_ready) begin
        pending <= 1'b0;                      // Dropped or just answered.
      end else if (!pending) begin
        lfsr <= lfsr_b;
        if (draw == 2'd0 || draw == 2'd3) begin
          imem_ready <= 1'b1;
        end else begin
          pending <= 1'b1;
          wait_cnt <= draw - 2'd1;
        end
      end else if (wait_cnt == 2'd0) begin
        imem_ready <= 1'b1;
        pending <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

endmodule

// File: verilog/fetch_assembler.sv
`timescale 1ns/1ps

module fetch_assembler import fetch_pkg::*; (
  input logic fetch_valid,
  input addr_t fetch_addr,
  input logic halt,
  fetch_buffer_if.reader buffer,
  output logic fetch_ready,
  output word_t fetch_rdata,
  output logic fetch_error,
  output count_t step
);

  addr_t next_addr;
  logic byp_cur;
  logic byp_nxt;
  entry_t cur;
  entry_t nxt;
  logic have_cur;
  logic have_nxt;
  logic [15:0] low_half;
  logic compressed;
  logic hit;
  word_t data;
  logic err;

  function automatic logic entry_match(entry_t e, addr_t a);
    return e.valid && (e.tag == a[31:2]);
  endfunction

  assign next_addr = fetch_addr + 32'd4;
  assign buffer.raddr1 = fetch_addr[index_w+1:2];
  assign buffer.raddr2 = next_addr[index_w+1:2];

  // The word being written wins over storage.
  assign byp_cur = buffer.wen & entry_match(buffer.wdata, fetch_addr);
  assign byp_nxt = buffer.wen & entry_match(buffer.wdata, next_addr);
  assign cur = byp_cur ? buffer.wdata : buffer.rdata1;
  assign nxt = byp_nxt ? buffer.wdata : buffer.rdata2;
  assign have_cur = byp_cur | entry_match(buffer.rdata1, fetch_addr);
  assign have_nxt = byp_nxt | entry_match(buffer.rdata2, next_addr);

  assign low_half = fetch_addr[1] ? cur.data[31:16] : cur.data[15:0];
  assign compressed = low_half[1:0] != 2'b11;

  always_comb begin
    hit = have_cur;
    data = cur.data;
    err = cur.error;
    if (compressed) begin
      data = {16'h0000, low_half};
    end else if (fetch_addr[1]) begin
      hit = have_cur & have_nxt;         // Crosses into the next word.
      data = {nxt.data[15:0], low_half};
      err = cur.error | nxt.error;
    end
    fetch_ready = fetch_valid & ~halt & hit;
    fetch_rdata = '0;
    fetch_error = 1'b0;
    step = '0;
    if (fetch_ready) begin
      fetch_rdata = data;
      fetch_error = err;
      step = compressed ? count_t'(1) : count_t'(2);
    end
  end

endmodule

// File: verilog/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer import fetch_pkg::*; (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input logic fetch_fence,
  input logic fetch_spec,
  input addr_t fetch_addr,
  input logic imem_ready,
  input logic imem_error,
  input word_t imem_rdata,
  output logic fetch_ready,
  output word_t fetch_rdata,
  output logic fetch_error,
  output logic imem_valid,
  output addr_t imem_addr
);

  logic halt;
  logic redirect;
  addr_t redirect_addr;
  logic flush_done;
  addr_t prefetch_addr;
  logic prefetch_open;
  count_t step;

  fetch_buffer_if buffer ();

  assign imem_addr = prefetch_addr;

  fetch_buffer_ram ram_i (
    .clock  (clock),
    .buffer (buffer.ram)
  );

  fetch_sequencer seq_i (
    .clock         (clock),
    .reset         (reset),
    .fetch_valid   (fetch_valid),
    .fetch_fence   (fetch_fence),
    .fetch_spec    (fetch_spec),
    .fetch_addr    (fetch_addr),
    .imem_ready    (imem_ready),
    .imem_error    (imem_error),
    .imem_rdata    (imem_rdata),
    .prefetch_addr (prefetch_addr),
    .prefetch_open (prefetch_open),
    .buffer        (buffer.writer),
    .halt          (halt),
    .redirect      (redirect),
    .redirect_addr (redirect_addr),
    .flush_done    (flush_done),
    .imem_valid    (imem_valid)
  );

  // Every memory response is one refill.
  fetch_occupancy occ_i (
    .clock         (clock),
    .reset         (reset),
    .refill        (imem_ready),
    .step          (step),
    .redirect      (redirect),
    .redirect_addr (redirect_addr),
    .flush_done    (flush_done),
    .prefetch_addr (prefetch_addr),
    .prefetch_open (prefetch_open)
  );

  fetch_assembler asm_i (
    .fetch_valid (fetch_valid),
    .fetch_addr  (fetch_addr),
    .halt        (halt),
    .buffer      (buffer.reader),
    .fetch_ready (fetch_ready),
    .fetch_rdata (fetch_rdata),
    .fetch_error (fetch_error),
    .step        (step)
  );

endmodule

// File: verilog/fetch_buffer_if.sv
`timescale 1ns/1ps

interface fetch_buffer_if import fetch_pkg::*; ();

  logic wen;
  index_t waddr;
  entry_t wdata;

  index_t raddr1;     // Word at the request address.
  index_t raddr2;     // Word after it.
  entry_t rdata1;
  entry_t rdata2;

  modport ram (
    input wen,
    input waddr,
    input wdata,
    input raddr1,
    input raddr2,
    output rdata1,
    output rdata2
  );

  modport writer (
    output wen,
    output waddr,
    output wdata
  );

  // The write port is visible here for bypass.
  modport reader (
    input wen,
    input wdata,
    input rdata1,
    input rdata2,
    output raddr1,
    output raddr2
  );

endinterface

// File: verilog/fetch_buffer_ram.sv
`timescale 1ns/1ps

module fetch_buffer_ram import fetch_pkg::*; (
  input logic clock,
  fetch_buffer_if.ram buffer
);

  entry_t mem [fetch_depth] = '{default: '0};

  assign buffer.rdata1 = mem[buffer.raddr1];
  assign buffer.rdata2 = mem[buffer.raddr2];

  always_ff @(posedge clock) begin
    if (buffer.wen) begin
      mem[buffer.waddr] <= buffer.wdata;
    end
  end

endmodule

// File: verilog/fetch_occupancy.sv
`timescale 1ns/1ps

module fetch_occupancy import fetch_pkg::*; (
  input logic clock,
  input logic reset,
  input logic refill,
  input count_t step,
  input logic redirect,
  input addr_t redirect_addr,
  input logic flush_done,
  output addr_t prefetch_addr,
  output logic prefetch_open
);

  count_t count;
  count_t count_sum;
  count_t count_next;

  // A word written this cycle may be consumed in the same cycle.
  always_comb begin
    count_sum = count + (refill ? count_t'(2) : count_t'(0));
    count_next = count_sum;
    if (step <= count_sum) begin
      count_next = count_sum - step;
    end
  end

  assign prefetch_open = count < count_t'(fetch_limit);

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
      prefetch_addr <= '0;
    end else if (redirect || flush_done) begin
      count <= '0;
      prefetch_addr <= redirect_addr;    // Restart at the latched request.
    end else begin
      count <= count_next;
      if (refill) begin
        prefetch_addr <= prefetch_addr + 32'd4;
      end
    end
  end

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

  // ========================================
  // Buffer geometry
  // ========================================

  localparam int fetch_depth = 8;                   // Buffer entries.
  localparam int index_w = $clog2(fetch_depth);
  localparam int fetch_limit = 2 * fetch_depth - 2; // Halfwords at which prefetch stops.
  localparam int count_w = index_w + 2;

  // ========================================
  // Types
  // ========================================

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [29:0] tag_t;                       // Address bits 31 to 2.
  typedef logic [index_w-1:0] index_t;
  typedef logic [count_w-1:0] count_t;

  // One buffered word with its tag and status.
  typedef struct packed {
    logic error;
    logic valid;
    tag_t tag;
    word_t data;
  } entry_t;

  typedef enum logic [1:0] {
    idle,
    active,
    control,                                        // Waits for the memory to go quiet.
    flush
  } seq_state_t;

endpackage

// File: verilog/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer import fetch_pkg::*; (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input logic fetch_fence,
  input logic fetch_spec,
  input addr_t fetch_addr,
  input logic imem_ready,
  input logic imem_error,
  input word_t imem_rdata,
  input addr_t prefetch_addr,
  input logic prefetch_open,
  fetch_buffer_if.writer buffer,
  output logic halt,
  output logic redirect,
  output addr_t redirect_addr,
  output logic flush_done,
  output logic imem_valid
);

  seq_state_t state;
  seq_state_t state_next;
  index_t wid;
  index_t wid_next;
  logic pend_fence;
  logic pend_spec;
  addr_t pend_addr;
  logic imem_valid_q;
  logic ctrl_req;
  logic drained;

  assign ctrl_req = fetch_valid & (fetch_fence | fetch_spec);
  assign drained = ~imem_valid_q | imem_ready;   // No word left in flight.
  assign redirect_addr = {pend_addr[31:2], 2'b00};

  // ========================================
  // Next state and buffer writes
  // ========================================

  always_comb begin
    state_next = state;
    wid_next = wid;
    halt = 1'b1;
    redirect = 1'b0;
    flush_done = 1'b0;
    buffer.wen = 1'b0;
    buffer.waddr = '0;
    buffer.wdata = '0;
    case (state)
      idle: begin
        state_next = active;
      end
      active: begin
        halt = ctrl_req;
        if (ctrl_req) begin
          state_next = control;
        end
        if (imem_ready) begin
          buffer.wen = 1'b1;
          buffer.waddr = prefetch_addr[index_w+1:2];
          buffer.wdata = '{error: imem_error, valid: 1'b1,
                           tag: prefetch_addr[31:2], data: imem_rdata};
        end
      end
      control: begin
        if (drained) begin
          if (pend_fence) begin
            state_next = flush;
            wid_next = '0;
            buffer.wen = 1'b1;                   // Entry 0 cleared here.
          end else begin
            state_next = active;
            redirect = pend_spec;
          end
        end
      end
      flush: begin
        if (&wid) begin
          state_next = active;
          flush_done = 1'b1;
        end else begin
          wid_next = wid + 1'b1;
          buffer.wen = 1'b1;
          buffer.waddr = wid_next;
        end
      end
      default: begin
        state_next = idle;
      end
    endcase
    imem_valid = halt ? 1'b0 : prefetch_open;
    if (redirect) begin
      imem_valid = 1'b1;
    end
  end

  // ========================================
  // Registers
  // ========================================

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
      wid <= '0;
      pend_fence <= 1'b0;
      pend_spec <= 1'b0;
      imem_valid_q <= 1'b0;
    end else begin
      state <= state_next;
      wid <= wid_next;
      imem_valid_q <= imem_valid;
      if (state == active && ctrl_req) begin
        pend_fence <= fetch_fence;
        pend_spec <= fetch_spec;
      end else if (state == control && drained) begin
        pend_fence <= 1'b0;
        pend_spec <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == active && ctrl_req) begin
      pend_addr <= fetch_addr;
    end
  end

endmodule
